// File: lsxp_bus_pkg.sv
package lsxp_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axil_r_t;

    // Shared by all slots. Select is per slot.
    typedef struct packed {
        addr_t      paddr;
        logic       pwrite;
        data_t      pwdata;
        strb_t      pstrb;
        logic [2:0] pprot;
        logic       penable;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// File: lsxp_map_pkg.sv
package lsxp_map_pkg;

    // Eight peripheral slots of 1 KiB each.
    localparam int NUM_SLOTS = 8;
    localparam int SLOT_BITS = 10;            // Log2 of slot size in bytes.

    // Start of slot 0.
    localparam logic [31:0] MAP_BASE = 32'h0000_0000;

    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;

endpackage

// File: lsxp_chan_hold.sv
module lsxp_chan_hold #(
    parameter type payload_t = logic
) (
    input  logic     seq,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_pop,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    assign in_ready  = ~full;                 // Ready only while empty.
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge seq) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// File: lsxp_axil_front.sv
module lsxp_axil_front (
    input  logic                   seq,
    input  logic                   rst_n,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  lsxp_bus_pkg::axil_aw_t aw,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  lsxp_bus_pkg::axil_w_t  w,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  lsxp_bus_pkg::axil_ar_t ar,
    output logic                   b_valid,
    input  logic                   b_ready,
    output lsxp_bus_pkg::resp_t    b_resp,
    output logic                   r_valid,
    input  logic                   r_ready,
    output lsxp_bus_pkg::axil_r_t  r,
    output logic                   cmd_valid,
    output logic                   cmd_write,
    output lsxp_bus_pkg::addr_t    cmd_addr,
    output logic [2:0]             cmd_prot,
    output lsxp_bus_pkg::data_t    cmd_wdata,
    output lsxp_bus_pkg::strb_t    cmd_strb,
    input  logic                   cmd_done,
    input  lsxp_bus_pkg::data_t    cmd_rdata,
    input  lsxp_bus_pkg::resp_t    cmd_resp
);

    import lsxp_bus_pkg::*;

    axil_aw_t aw_q;
    axil_w_t  w_q;
    axil_ar_t ar_q;
    logic     aw_held, w_held, ar_held;
    logic     pop_wr, pop_rd;
    logic     wr_elig, rd_elig;
    logic     pick_wr, start;
    logic     prio_wr;

    lsxp_chan_hold #(.payload_t(axil_aw_t)) aw_hold (
        .seq(seq), .rst_n(rst_n),
        .in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
        .out_valid(aw_held), .out_pop(pop_wr), .out_data(aw_q)
    );

    lsxp_chan_hold #(.payload_t(axil_w_t)) w_hold (
        .seq(seq), .rst_n(rst_n),
        .in_valid(w_valid), .in_ready(w_ready), .in_data(w),
        .out_valid(w_held), .out_pop(pop_wr), .out_data(w_q)
    );

    lsxp_chan_hold #(.payload_t(axil_ar_t)) ar_hold (
        .seq(seq), .rst_n(rst_n),
        .in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
        .out_valid(ar_held), .out_pop(pop_rd), .out_data(ar_q)
    );

    assign wr_elig = aw_held && w_held;       // Write needs both address and data.
    assign rd_elig = ar_held;
    assign pick_wr = wr_elig && (!rd_elig || prio_wr);
    assign start   = !cmd_valid && !b_valid && !r_valid && (wr_elig || rd_elig);

    assign pop_wr = cmd_done && cmd_write;
    assign pop_rd = cmd_done && !cmd_write;

    // Held items stay put until popped, so the command is stable.
    assign cmd_addr  = cmd_write ? aw_q.addr : ar_q.addr;
    assign cmd_prot  = cmd_write ? aw_q.prot : ar_q.prot;
    assign cmd_wdata = w_q.data;
    assign cmd_strb  = w_q.strb;

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            cmd_write <= 1'b0;
            prio_wr   <= 1'b1;                // Write goes first after reset.
            b_valid   <= 1'b0;
            r_valid   <= 1'b0;
        end else begin
            if (start) begin
                cmd_valid <= 1'b1;
                cmd_write <= pick_wr;
                prio_wr   <= !pick_wr;
            end else if (cmd_done) begin
                cmd_valid <= 1'b0;
            end
            if (pop_wr) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (pop_rd) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (pop_wr) begin
            b_resp <= cmd_resp;
        end
        if (pop_rd) begin
            r.data <= cmd_rdata;
            r.resp <= cmd_resp;
        end
    end

endmodule

// File: lsxp_apb_master.sv
module lsxp_apb_master (
    input  logic                                 seq,
    input  logic                                 rst_n,
    input  logic                                 pause,
    input  logic                                 cmd_valid,
    input  logic                                 cmd_write,
    input  lsxp_bus_pkg::addr_t                  cmd_addr,
    input  logic [2:0]                           cmd_prot,
    input  lsxp_bus_pkg::data_t                  cmd_wdata,
    input  lsxp_bus_pkg::strb_t                  cmd_strb,
    output logic                                 cmd_done,
    output lsxp_bus_pkg::data_t                  cmd_rdata,
    output lsxp_bus_pkg::resp_t                  cmd_resp,
    output logic [lsxp_map_pkg::NUM_SLOTS-1:0]   psel,
    output lsxp_bus_pkg::apb_req_t               apb_req,
    input  lsxp_bus_pkg::apb_rsp_t               apb_rsp [lsxp_map_pkg::NUM_SLOTS]
);

    import lsxp_bus_pkg::*;
    import lsxp_map_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_t;

    state_t    state;
    addr_t     offset;
    slot_idx_t slot_d, slot_q;
    logic      in_map;
    logic      start;
    logic      dec_q;
    apb_rsp_t  sel_rsp;

    assign offset = cmd_addr - MAP_BASE;
    assign slot_d = offset[SLOT_BITS +: $bits(slot_idx_t)];
    assign in_map = (offset >> SLOT_BITS) < addr_t'(NUM_SLOTS);  // Below the base wraps high.

    // Pause only blocks the step into setup.
    assign start = (state == ST_IDLE) && cmd_valid && in_map && !pause;

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            dec_q <= 1'b0;
        end else begin
            dec_q <= (state == ST_IDLE) && cmd_valid && !in_map && !dec_q;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    state <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (sel_rsp.pready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (start) begin
            slot_q <= slot_d;
        end
    end

    assign sel_rsp = apb_rsp[slot_q];

    always_comb begin
        psel = '0;
        if (state != ST_IDLE) begin
            psel[slot_q] = 1'b1;
        end
    end

    always_comb begin
        apb_req.paddr   = cmd_addr;
        apb_req.pwrite  = cmd_write;
        apb_req.pwdata  = cmd_wdata;
        apb_req.pstrb   = cmd_write ? cmd_strb : '0;  // Reads carry no strobes.
        apb_req.pprot   = cmd_prot;
        apb_req.penable = (state == ST_ACCESS);
    end

    assign cmd_done  = ((state == ST_ACCESS) && sel_rsp.pready) || dec_q;
    assign cmd_rdata = dec_q ? '0 : sel_rsp.prdata;

    always_comb begin
        if (dec_q) begin
            cmd_resp = RESP_DECERR;               // Unmapped, APB untouched.
        end else if (sel_rsp.pslverr) begin
            cmd_resp = RESP_SLVERR;
        end else begin
            cmd_resp = RESP_OKAY;
        end
    end

endmodule

// File: lsxp_fabric.sv
module lsxp_fabric (
    input  logic                                 seq,
    input  logic                                 rst_n,
    input  logic                                 pause,
    input  logic                                 aw_valid,
    output logic                                 aw_ready,
    input  lsxp_bus_pkg::axil_aw_t               aw,
    input  logic                                 w_valid,
    output logic                                 w_ready,
    input  lsxp_bus_pkg::axil_w_t                w,
    input  logic                                 ar_valid,
    output logic                                 ar_ready,
    input  lsxp_bus_pkg::axil_ar_t               ar,
    output logic                                 b_valid,
    input  logic                                 b_ready,
    output lsxp_bus_pkg::resp_t                  b_resp,
    output logic                                 r_valid,
    input  logic                                 r_ready,
    output lsxp_bus_pkg::axil_r_t                r,
    output logic [lsxp_map_pkg::NUM_SLOTS-1:0]   psel,
    output lsxp_bus_pkg::apb_req_t               apb_req,
    input  lsxp_bus_pkg::apb_rsp_t               apb_rsp [lsxp_map_pkg::NUM_SLOTS]
);

    import lsxp_bus_pkg::*;

    logic       cmd_valid;
    logic       cmd_write;
    addr_t      cmd_addr;
    logic [2:0] cmd_prot;
    data_t      cmd_wdata;
    strb_t      cmd_strb;
    logic       cmd_done;
    data_t      cmd_rdata;
    resp_t      cmd_resp;

    lsxp_axil_front front (
        .seq(seq), .rst_n(rst_n),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .r_valid(r_valid), .r_ready(r_ready), .r(r),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_addr(cmd_addr),
        .cmd_prot(cmd_prot), .cmd_wdata(cmd_wdata), .cmd_strb(cmd_strb),
        .cmd_done(cmd_done), .cmd_rdata(cmd_rdata), .cmd_resp(cmd_resp)
    );

    lsxp_apb_master apb_mst (
        .seq(seq), .rst_n(rst_n), .pause(pause),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_addr(cmd_addr),
        .cmd_prot(cmd_prot), .cmd_wdata(cmd_wdata), .cmd_strb(cmd_strb),
        .cmd_done(cmd_done), .cmd_rdata(cmd_rdata), .cmd_resp(cmd_resp),
        .psel(psel), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

endmodule

// File: lsxp_sva.sv
module lsxp_sva (
    input logic                               seq,
    input logic                               rst_n,
    input logic [lsxp_map_pkg::NUM_SLOTS-1:0] psel,
    input lsxp_bus_pkg::apb_req_t             apb_req,
    input lsxp_bus_pkg::apb_rsp_t             sel_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    logic setup;

    assign setup = |psel && !apb_req.penable;  // Selected but not yet enabled.

    a_psel_onehot: assert property (@(posedge seq) disable iff (!rst_n) $onehot0(psel))
        else $error("more than one psel bit is high");

    a_setup_to_access: assert property (@(posedge seq) disable iff (!rst_n)
        setup |=> apb_req.penable)
        else $error("setup phase not followed by an access phase");

    a_access_after_setup: assert property (@(posedge seq) disable iff (!rst_n)
        $rose(apb_req.penable) |-> $past(setup))
        else $error("penable rose without a setup cycle");

    a_req_stable: assert property (@(posedge seq) disable iff (!rst_n)
        (apb_req.penable && !sel_rsp.pready) |=> ($stable(apb_req) && $stable(psel)))
        else $error("APB request changed during wait states");

endmodule

bind lsxp_apb_master lsxp_sva sva0 (
    .seq(seq), .rst_n(rst_n), .psel(psel), .apb_req(apb_req), .sel_rsp(sel_rsp)
);

// File: tb_lsxp.sv
module tb_lsxp;
    timeunit 1ns;
    timeprecision 1ps;

    import lsxp_bus_pkg::*;
    import lsxp_map_pkg::*;

    localparam int         TIMEOUT = 200;     // Cycles allowed for any single wait.
    localparam logic [1:0] K_WR    = 2'd0;
    localparam logic [1:0] K_RD    = 2'd1;
    localparam logic [1:0] K_BOTH  = 2'd2;    // Write and read offered together.

    typedef struct packed {
        logic [1:0] kind;
        addr_t      addr;
        data_t      data;
        strb_t      strb;
        logic       pause;
        resp_t      resp;
    } row_t;

    logic                 seq = 1'b0;
    logic                 rst_n, pause;
    logic                 aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic                 b_valid, b_ready, r_valid, r_ready;
    axil_aw_t             aw;
    axil_w_t              w;
    axil_ar_t             ar;
    resp_t                b_resp;
    axil_r_t              r;
    logic [NUM_SLOTS-1:0] psel;
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp [NUM_SLOTS];

    data_t       slot_mem [NUM_SLOTS][256];
    logic [1:0]  wait_cnt [NUM_SLOTS];
    logic [31:0] rng;
    int          psel_cycles = 0;
    int          cur_row = 0;
    data_t       ref_mem [NUM_SLOTS*256];
    row_t        rows [$];
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    lsxp_fabric dut0 (
        .seq(seq), .rst_n(rst_n), .pause(pause),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .r_valid(r_valid), .r_ready(r_ready), .r(r),
        .psel(psel), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    always #2 seq = ~seq;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t fill_word(input int byte_addr);
        return data_t'(byte_addr * 40503) ^ 32'h5EED_0000;  // Distinct for every word.
    endfunction

    function automatic logic [2:0] row_prot(input int row, input logic write);
        return write ? 3'(row) : ~3'(row);    // Write and read of a row differ.
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic void add_row(input logic [1:0] kind, input addr_t addr, input data_t data,
                                    input strb_t strb, input logic pause_on, input resp_t resp);
        rows.push_back(row_t'{kind, addr, data, strb, pause_on, resp});
    endfunction

    // APB slot models with random wait states.
    always @(posedge seq) begin
        if (!rst_n) begin
            rng <= 32'd96;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                wait_cnt[i] <= 2'd0;
                for (int j = 0; j < 256; j++) begin
                    slot_mem[i][j] <= fill_word(i * 1024 + j * 4);
                end
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (psel[i] && !apb_req.penable) begin
                    rng         <= lcg_next(rng);
                    wait_cnt[i] <= rng[17:16];
                end else if (psel[i] && wait_cnt[i] != 2'd0) begin
                    wait_cnt[i] <= wait_cnt[i] - 2'd1;
                end else if (psel[i] && apb_req.pwrite && !apb_rsp[i].pslverr) begin
                    slot_mem[i][apb_req.paddr[9:2]] <= merge_bytes(
                        slot_mem[i][apb_req.paddr[9:2]], apb_req.pwdata, apb_req.pstrb);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            apb_rsp[i].prdata  = slot_mem[i][apb_req.paddr[9:2]];
            apb_rsp[i].pready  = psel[i] && apb_req.penable && (wait_cnt[i] == 2'd0);
            apb_rsp[i].pslverr = psel[i] && apb_req.penable && (i == 5)
                                 && (apb_req.paddr[9:2] == 8'h3F);
        end
    end

    task automatic check_value(input string sig, input int row, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s in row %0d: got %h, expected %h", sig, row, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    always @(posedge seq) begin
        if (|psel) begin
            psel_cycles <= psel_cycles + 1;
            check_value("apb_req.pprot", cur_row, 32'(apb_req.pprot),
                        32'(row_prot(cur_row, apb_req.pwrite)));
        end
    end

    task automatic run_row(input row_t rw, input int k);
        int          cnt;
        int          psel_start;
        logic        take_aw, take_w, take_ar, early_r;
        logic [10:0] idx;
        idx        = rw.addr[12:2];
        cur_row    = k;
        psel_start = psel_cycles;
        pause      = rw.pause;
        aw         = '{addr: rw.addr, prot: row_prot(k, 1'b1)};
        w          = '{data: rw.data, strb: rw.strb};
        ar         = '{addr: rw.addr, prot: row_prot(k, 1'b0)};
        aw_valid   = (rw.kind != K_RD);
        w_valid    = (rw.kind != K_RD);
        ar_valid   = (rw.kind != K_WR);
        cnt = 0;
        while ((aw_valid || w_valid || ar_valid) && cnt < TIMEOUT) begin
            take_aw = aw_ready;               // Ready is stable between rising edges.
            take_w  = w_ready;
            take_ar = ar_ready;
            @(negedge seq);
            aw_valid = aw_valid && !take_aw;
            w_valid  = w_valid && !take_w;
            ar_valid = ar_valid && !take_ar;
            cnt++;
        end
        if (aw_valid || w_valid || ar_valid) begin
            expect_true(1'b0, $sformatf("request channels never accepted in row %0d", k));
            timed_out = 1'b1;
            return;
        end
        if (rw.pause) begin
            repeat (20) begin
                expect_true(psel_cycles == psel_start && !b_valid && !r_valid,
                            $sformatf("bus activity while paused in row %0d", k));
                @(negedge seq);
            end
            pause = 1'b0;
        end
        if (rw.kind != K_RD) begin
            cnt     = 0;
            early_r = 1'b0;
            while (!b_valid && cnt < TIMEOUT) begin
                early_r = early_r || r_valid;
                @(negedge seq);
                cnt++;
            end
            if (!b_valid) begin
                expect_true(1'b0, $sformatf("no write response in time in row %0d", k));
                timed_out = 1'b1;
                return;
            end
            expect_true(!early_r, $sformatf("read finished before the write in row %0d", k));
            check_value("b_resp", k, 32'(b_resp), 32'(rw.resp));
            if (rw.resp == RESP_OKAY) begin
                ref_mem[idx] = merge_bytes(ref_mem[idx], rw.data, rw.strb);
            end
        end
        if (rw.kind != K_WR) begin
            cnt = 0;
            while (!r_valid && cnt < TIMEOUT) begin
                @(negedge seq);
                cnt++;
            end
            if (!r_valid) begin
                expect_true(1'b0, $sformatf("no read response in time in row %0d", k));
                timed_out = 1'b1;
                return;
            end
            check_value("r.resp", k, 32'(r.resp), 32'(rw.resp));
            if (rw.resp == RESP_OKAY) begin
                check_value("r.data", k, r.data, ref_mem[idx]);
            end
        end
        if (rw.resp == RESP_DECERR) begin
            expect_true(psel_cycles == psel_start,
                        $sformatf("psel raised for an unmapped address in row %0d", k));
        end
    endtask

    initial begin
        addr_t base;
        rst_n    = 1'b0;
        pause    = 1'b0;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        ar_valid = 1'b0;
        aw       = '0;
        w        = '0;
        ar       = '0;
        b_ready  = 1'b1;
        r_ready  = 1'b1;
        for (int a = 0; a < NUM_SLOTS * 256; a++) begin
            ref_mem[a] = fill_word(a * 4);
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            base = MAP_BASE + (addr_t'(s) << SLOT_BITS);
            add_row(K_WR, base, 32'hA100_0000 | data_t'(s), 4'hF, 1'b0, RESP_OKAY);
            add_row(K_RD, base, '0, '0, 1'b0, RESP_OKAY);
            add_row(K_WR, base + 32'd1023, 32'hC0FF_FFFF + (data_t'(s) << 24), 4'h8, 1'b0,
                    RESP_OKAY);                   // Last byte sits in lane 3.
            add_row(K_RD, base + 32'd1023, '0, '0, 1'b0, RESP_OKAY);
        end
        add_row(K_WR, 32'h0000_0840, 32'h1234_5678, 4'hF, 1'b0, RESP_OKAY);
        add_row(K_WR, 32'h0000_0840, 32'hAABB_CCDD, 4'h5, 1'b0, RESP_OKAY);
        add_row(K_WR, 32'h0000_0840, 32'h0000_EE00, 4'h2, 1'b0, RESP_OKAY);
        add_row(K_RD, 32'h0000_0840, '0, '0, 1'b0, RESP_OKAY);
        add_row(K_WR, 32'h0000_14FC, 32'hDEAD_BEEF, 4'hF, 1'b0, RESP_SLVERR);
        add_row(K_RD, 32'h0000_14FC, '0, '0, 1'b0, RESP_SLVERR);
        add_row(K_WR, 32'h0000_2000, 32'h0BAD_0BAD, 4'hF, 1'b0, RESP_DECERR);
        add_row(K_RD, 32'h0000_2000, '0, '0, 1'b0, RESP_DECERR);
        add_row(K_RD, 32'hFFFF_FFFC, '0, '0, 1'b0, RESP_DECERR);
        add_row(K_WR, 32'h0000_0C40, 32'hCAFE_BABE, 4'hF, 1'b1, RESP_OKAY);
        add_row(K_RD, 32'h0000_0C40, '0, '0, 1'b1, RESP_OKAY);
        add_row(K_BOTH, 32'h0000_1880, 32'h600D_F00D, 4'hF, 1'b0, RESP_OKAY);
        add_row(K_RD, 32'h0000_1880, '0, '0, 1'b0, RESP_OKAY);

        repeat (2) @(posedge seq);
        @(negedge seq);
        rst_n = 1'b1;
        foreach (rows[k]) begin
            if (!timed_out) begin
                @(negedge seq);
                run_row(rows[k], k);
            end
        end
        $display("Ran %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
lsxp_bus_pkg.sv
lsxp_map_pkg.sv
lsxp_chan_hold.sv
lsxp_axil_front.sv
lsxp_apb_master.sv
lsxp_fabric.sv
lsxp_sva.sv
tb_lsxp.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_lsxp
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
